//--- all.f
src/cpu_pkg.sv
src/regfile.sv
src/decode_unit.sv
src/forward_unit.sv
src/alu.sv
src/cpu_core.sv
bench/cpu_asserts.sv
bench/tb_cpu.sv

//--- Bender.yml
package:
  name: mips_pipeline

sources:
  - src/cpu_pkg.sv
  - src/regfile.sv
  - src/decode_unit.sv
  - src/forward_unit.sv
  - src/alu.sv
  - src/cpu_core.sv
  - target: simulation
    files:
      - bench/cpu_asserts.sv
      - bench/tb_cpu.sv

//--- bench/tb_cpu.sv
`timescale 1ns/10ps
`default_nettype none

module tb_cpu;

    typedef struct packed {
        cpu_pkg::word_t     pc;
        cpu_pkg::reg_addr_t num;
        cpu_pkg::word_t     data;
    } exp_write_t;

    logic                clk;
    logic                reset;
    cpu_pkg::word_t      imem_addr;
    cpu_pkg::word_t      imem_rdata;
    cpu_pkg::dmem_req_t  dmem;
    cpu_pkg::word_t      dmem_rdata;
    cpu_pkg::wb_trace_t  trace;

    cpu_pkg::word_t      imem_words [256];
    cpu_pkg::word_t      dmem_words [64];
    cpu_pkg::word_t      model_regs [32];
    cpu_pkg::word_t      model_mem [64];
    cpu_pkg::word_t      model_pc;
    cpu_pkg::word_t      model_npc;
    cpu_pkg::word_t      halt_pc;
    exp_write_t          exp_q [$];
    int                  prog_len;
    int                  errors;
    int                  test_errors;
    int                  retired;
    int                  tests;

    cpu_core uut (
        .clk        (clk),
        .reset      (reset),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .dmem       (dmem),
        .dmem_rdata (dmem_rdata),
        .trace      (trace)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // both memories answer one cycle after the request edge
    always @(posedge clk) begin
        cpu_pkg::word_t     fetch_addr;
        cpu_pkg::dmem_req_t req;
        fetch_addr = imem_addr;
        req = dmem;
        #1;
        imem_rdata = imem_words[fetch_addr[9:2]];
        if (req.en === 1'b1) begin
            if (req.wen == 4'hf) begin
                dmem_words[req.addr[7:2]] = req.wdata;
            end
            dmem_rdata = dmem_words[req.addr[7:2]];
        end
    end

    // trace checker compares in program order
    always @(negedge clk) begin
        exp_write_t e;
        if (!reset && trace.valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("ERR %0t unexpected write at %h r%0d = %h",
                         $time, trace.pc, trace.wnum, trace.wdata);
                test_errors++;
            end else begin
                e = exp_q.pop_front();
                retired++;
                if (trace.pc !== e.pc || trace.wnum !== e.num || trace.wdata !== e.data) begin
                    $display("ERR %0t write at %h r%0d = %h, expected at %h r%0d = %h",
                             $time, trace.pc, trace.wnum, trace.wdata, e.pc, e.num, e.data);
                    test_errors++;
                end
            end
        end
    end

    function automatic cpu_pkg::word_t rtype_word(logic [5:0] fn, cpu_pkg::reg_addr_t rs,
                                                  cpu_pkg::reg_addr_t rt, cpu_pkg::reg_addr_t rd,
                                                  logic [4:0] sh);
        return {cpu_pkg::op_special, rs, rt, rd, sh, fn};
    endfunction

    function automatic cpu_pkg::word_t itype_word(logic [5:0] op, cpu_pkg::reg_addr_t rs,
                                                  cpu_pkg::reg_addr_t rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // architectural model steps one instruction per call
    function automatic bit model_step(output cpu_pkg::word_t wpc,
                                      output cpu_pkg::reg_addr_t wnum,
                                      output cpu_pkg::word_t wdata);
        cpu_pkg::word_t     instr;
        cpu_pkg::word_t     a;
        cpu_pkg::word_t     b;
        cpu_pkg::word_t     simm;
        cpu_pkg::word_t     zimm;
        cpu_pkg::word_t     addr;
        cpu_pkg::word_t     target;
        bit                 has;
        bit                 taken;
        instr  = imem_words[model_pc[9:2]];
        a      = model_regs[instr[25:21]];
        b      = model_regs[instr[20:16]];
        simm   = {{16{instr[15]}}, instr[15:0]};
        zimm   = {16'h0000, instr[15:0]};
        addr   = a + simm;
        target = model_npc + (simm << 2);
        wpc    = model_pc;
        wnum   = instr[20:16];
        wdata  = '0;
        has    = 1'b1;
        taken  = 1'b0;
        case (instr[31:26])
            cpu_pkg::op_special: begin
                wnum = instr[15:11];
                case (instr[5:0])
                    cpu_pkg::fn_addu: wdata = a + b;
                    cpu_pkg::fn_subu: wdata = a - b;
                    cpu_pkg::fn_and:  wdata = a & b;
                    cpu_pkg::fn_or:   wdata = a | b;
                    cpu_pkg::fn_xor:  wdata = a ^ b;
                    cpu_pkg::fn_nor:  wdata = ~(a | b);
                    cpu_pkg::fn_slt:  wdata = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    cpu_pkg::fn_sltu: wdata = (a < b) ? 32'd1 : 32'd0;
                    cpu_pkg::fn_sll:  wdata = b << instr[10:6];
                    default:          has = 1'b0;
                endcase
            end
            cpu_pkg::op_addiu: wdata = a + simm;
            cpu_pkg::op_slti:  wdata = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
            cpu_pkg::op_andi:  wdata = a & zimm;
            cpu_pkg::op_ori:   wdata = a | zimm;
            cpu_pkg::op_lui:   wdata = {instr[15:0], 16'h0000};
            cpu_pkg::op_lw:    wdata = model_mem[addr[7:2]];
            cpu_pkg::op_sw: begin
                model_mem[addr[7:2]] = b;
                has = 1'b0;
            end
            cpu_pkg::op_beq: begin
                taken = (a == b);
                has = 1'b0;
            end
            cpu_pkg::op_bne: begin
                taken = (a != b);
                has = 1'b0;
            end
            cpu_pkg::op_j: begin
                taken = 1'b1;
                target = {model_npc[31:28], instr[25:0], 2'b00};
                has = 1'b0;
            end
            default: has = 1'b0;
        endcase
        if (wnum == '0) begin
            has = 1'b0;
        end
        if (has) begin
            model_regs[wnum] = wdata;
        end
        model_pc  = model_npc;
        model_npc = taken ? target : model_npc + 32'd4;
        return has;
    endfunction

    task automatic emit(input cpu_pkg::word_t w);
        imem_words[prog_len] = w;
        prog_len++;
    endtask

    task automatic emit_nops(input int n);
        repeat (n) emit(32'h0000_0000);
    endtask

    // reset goes up first so the old program cannot run into the new one
    task automatic start_program();
        @(posedge clk);
        #1 reset = 1'b1;
        for (int i = 0; i < 256; i++) begin
            imem_words[i] = 32'h0000_0000;
        end
        prog_len = 0;
        for (int r = 1; r < 8; r++) begin
            emit(itype_word(cpu_pkg::op_addiu, 5'd0, 5'(r), 16'(r * 16'h1235) ^ 16'h8000));
        end
    endtask

    task automatic finish_program();
        halt_pc = prog_len * 4;
        emit({cpu_pkg::op_j, 26'(prog_len)});
        emit_nops(1);
    endtask

    task automatic run_test(input string name);
        exp_write_t w;
        int         cycles;
        for (int i = 0; i < 64; i++) begin
            dmem_words[i] = (cpu_pkg::word_t'(i) * 32'h0104_1041) ^ 32'h9e37_0000;
            model_mem[i]  = dmem_words[i];
        end
        model_regs = '{default: '0};
        model_pc   = cpu_pkg::reset_pc;
        model_npc  = cpu_pkg::reset_pc + 32'd4;
        exp_q.delete();
        cycles = 0;
        while (model_pc != halt_pc && cycles < 4000) begin
            if (model_step(w.pc, w.num, w.data)) begin
                exp_q.push_back(w);
            end
            cycles++;
        end
        test_errors = 0;
        retired = 0;
        repeat (4) @(posedge clk);
        #1;
        if (imem_addr !== cpu_pkg::reset_pc || trace.valid !== 1'b0 || dmem.en !== 1'b0) begin
            $display("ERR %0t reset state wrong, imem_addr %h", $time, imem_addr);
            test_errors++;
        end
        @(posedge clk);
        #1 reset = 1'b0;
        cycles = 0;
        while (exp_q.size() != 0 && cycles < 3000) begin
            @(posedge clk);
            cycles++;
        end
        if (exp_q.size() != 0) begin
            $display("test %s timed out with %0d writes still missing", name, exp_q.size());
            test_errors++;
        end
        // extra writes would show up here
        repeat (20) @(posedge clk);
        $display("test %s: %0d writes retired, %0d errors", name, retired, test_errors);
        errors += test_errors;
        tests++;
    endtask

    task automatic emit_random_plain();
        cpu_pkg::reg_addr_t d;
        cpu_pkg::reg_addr_t s;
        cpu_pkg::reg_addr_t t;
        logic [15:0]        imm;
        logic [15:0]        offs;
        d    = 5'($urandom_range(0, 7));
        s    = 5'($urandom_range(0, 7));
        t    = 5'($urandom_range(0, 7));
        imm  = 16'($urandom);
        offs = 16'($urandom_range(0, 63) * 4);
        case ($urandom_range(0, 15))
            0:  emit(rtype_word(cpu_pkg::fn_addu, s, t, d, 5'd0));
            1:  emit(rtype_word(cpu_pkg::fn_subu, s, t, d, 5'd0));
            2:  emit(rtype_word(cpu_pkg::fn_and, s, t, d, 5'd0));
            3:  emit(rtype_word(cpu_pkg::fn_or, s, t, d, 5'd0));
            4:  emit(rtype_word(cpu_pkg::fn_xor, s, t, d, 5'd0));
            5:  emit(rtype_word(cpu_pkg::fn_nor, s, t, d, 5'd0));
            6:  emit(rtype_word(cpu_pkg::fn_slt, s, t, d, 5'd0));
            7:  emit(rtype_word(cpu_pkg::fn_sltu, s, t, d, 5'd0));
            8:  emit(rtype_word(cpu_pkg::fn_sll, 5'd0, t, d, 5'($urandom)));
            9:  emit(itype_word(cpu_pkg::op_addiu, s, d, imm));
            10: emit(itype_word(cpu_pkg::op_andi, s, d, imm));
            11: emit(itype_word(cpu_pkg::op_ori, s, d, imm));
            12: emit(itype_word(cpu_pkg::op_lui, 5'd0, d, imm));
            13: emit(itype_word(cpu_pkg::op_slti, s, d, imm));
            14: emit(itype_word(cpu_pkg::op_lw, 5'd0, d, offs));
            default: emit(itype_word(cpu_pkg::op_sw, 5'd0, t, offs));
        endcase
    endtask

    initial begin
        int halt_idx;
        int off;
        void'($urandom(32'h5a0e6a2a));
        reset      = 1'b1;
        imem_rdata = '0;
        dmem_rdata = '0;
        errors     = 0;
        tests      = 0;

        start_program();
        emit(rtype_word(cpu_pkg::fn_addu, 5'd1, 5'd2, 5'd8, 5'd0));
        emit_nops(3);
        emit(rtype_word(cpu_pkg::fn_subu, 5'd1, 5'd3, 5'd9, 5'd0));
        emit_nops(3);
        emit(rtype_word(cpu_pkg::fn_and, 5'd2, 5'd3, 5'd10, 5'd0));
        emit_nops(3);
        emit(rtype_word(cpu_pkg::fn_or, 5'd4, 5'd5, 5'd11, 5'd0));
        emit_nops(3);
        emit(rtype_word(cpu_pkg::fn_xor, 5'd6, 5'd7, 5'd12, 5'd0));
        emit_nops(3);
        emit(rtype_word(cpu_pkg::fn_nor, 5'd1, 5'd4, 5'd13, 5'd0));
        emit_nops(3);
        emit(rtype_word(cpu_pkg::fn_slt, 5'd2, 5'd1, 5'd14, 5'd0));
        emit_nops(3);
        emit(rtype_word(cpu_pkg::fn_sltu, 5'd2, 5'd1, 5'd15, 5'd0));
        emit_nops(3);
        emit(rtype_word(cpu_pkg::fn_sll, 5'd0, 5'd3, 5'd16, 5'd7));
        emit_nops(3);
        emit(itype_word(cpu_pkg::op_lui, 5'd0, 5'd17, 16'h1234));
        emit_nops(3);
        emit(itype_word(cpu_pkg::op_addiu, 5'd2, 5'd18, 16'hfffd));
        emit_nops(3);
        emit(itype_word(cpu_pkg::op_andi, 5'd6, 5'd19, 16'hf0f0));
        emit_nops(3);
        emit(itype_word(cpu_pkg::op_ori, 5'd5, 5'd20, 16'h8001));
        emit_nops(3);
        emit(itype_word(cpu_pkg::op_slti, 5'd2, 5'd21, 16'h0004));
        finish_program();
        run_test("alu_independent");

        // dependence distances 1, 2 and 3
        start_program();
        emit(rtype_word(cpu_pkg::fn_addu, 5'd1, 5'd2, 5'd8, 5'd0));
        emit(rtype_word(cpu_pkg::fn_subu, 5'd8, 5'd3, 5'd9, 5'd0));
        emit_nops(1);
        emit(rtype_word(cpu_pkg::fn_or, 5'd9, 5'd5, 5'd10, 5'd0));
        emit_nops(2);
        emit(rtype_word(cpu_pkg::fn_and, 5'd10, 5'd6, 5'd11, 5'd0));
        emit(rtype_word(cpu_pkg::fn_sll, 5'd0, 5'd11, 5'd12, 5'd3));
        emit(rtype_word(cpu_pkg::fn_addu, 5'd12, 5'd12, 5'd13, 5'd0));
        emit_nops(2);
        emit(rtype_word(cpu_pkg::fn_xor, 5'd13, 5'd12, 5'd14, 5'd0));
        emit(itype_word(cpu_pkg::op_addiu, 5'd14, 5'd14, 16'h0101));
        emit(itype_word(cpu_pkg::op_slti, 5'd14, 5'd15, 16'h7fff));
        finish_program();
        run_test("forward_chains");

        start_program();
        emit(itype_word(cpu_pkg::op_sw, 5'd0, 5'd5, 16'd16));
        emit(itype_word(cpu_pkg::op_lw, 5'd0, 5'd8, 16'd16));
        emit(rtype_word(cpu_pkg::fn_addu, 5'd8, 5'd1, 5'd9, 5'd0));
        emit(itype_word(cpu_pkg::op_lw, 5'd0, 5'd10, 16'd16));
        emit_nops(1);
        emit(rtype_word(cpu_pkg::fn_subu, 5'd10, 5'd8, 5'd11, 5'd0));
        emit(itype_word(cpu_pkg::op_sw, 5'd0, 5'd9, 16'd20));
        emit(itype_word(cpu_pkg::op_lw, 5'd0, 5'd12, 16'd20));
        emit(itype_word(cpu_pkg::op_sw, 5'd0, 5'd12, 16'd24));
        emit(itype_word(cpu_pkg::op_lw, 5'd0, 5'd13, 16'd24));
        emit(rtype_word(cpu_pkg::fn_or, 5'd0, 5'd13, 5'd14, 5'd0));
        finish_program();
        run_test("load_store");

        start_program();
        emit(itype_word(cpu_pkg::op_beq, 5'd1, 5'd1, 16'd2));
        emit(itype_word(cpu_pkg::op_addiu, 5'd0, 5'd8, 16'd1));
        emit(itype_word(cpu_pkg::op_addiu, 5'd0, 5'd9, 16'd2));
        emit(itype_word(cpu_pkg::op_bne, 5'd1, 5'd1, 16'd1));
        emit(itype_word(cpu_pkg::op_addiu, 5'd0, 5'd10, 16'd3));
        emit(itype_word(cpu_pkg::op_addiu, 5'd0, 5'd11, 16'd4));
        emit(itype_word(cpu_pkg::op_beq, 5'd1, 5'd2, 16'd1));
        emit(itype_word(cpu_pkg::op_addiu, 5'd0, 5'd12, 16'd5));
        emit(itype_word(cpu_pkg::op_addiu, 5'd0, 5'd13, 16'd6));
        emit(itype_word(cpu_pkg::op_bne, 5'd1, 5'd2, 16'd3));
        emit(itype_word(cpu_pkg::op_addiu, 5'd0, 5'd14, 16'd7));
        emit(itype_word(cpu_pkg::op_addiu, 5'd0, 5'd15, 16'd8));
        emit(itype_word(cpu_pkg::op_addiu, 5'd0, 5'd15, 16'd9));
        emit({cpu_pkg::op_j, 26'(prog_len + 3)});
        emit(itype_word(cpu_pkg::op_addiu, 5'd0, 5'd16, 16'd10));
        emit(itype_word(cpu_pkg::op_addiu, 5'd0, 5'd17, 16'd11));
        emit(itype_word(cpu_pkg::op_addiu, 5'd0, 5'd18, 16'd12));
        finish_program();
        run_test("branches");

        // forward-only branches and none in a delay slot
        start_program();
        halt_idx = prog_len + 200;
        while (prog_len < halt_idx) begin
            if ($urandom_range(0, 7) == 0 && halt_idx - prog_len >= 5) begin
                off = $urandom_range(1, 3);
                case ($urandom_range(0, 2))
                    0: emit(itype_word(cpu_pkg::op_beq, 5'($urandom_range(0, 7)),
                                       5'($urandom_range(0, 7)), 16'(off)));
                    1: emit(itype_word(cpu_pkg::op_bne, 5'($urandom_range(0, 7)),
                                       5'($urandom_range(0, 7)), 16'(off)));
                    default: emit({cpu_pkg::op_j, 26'(prog_len + 1 + off)});
                endcase
                emit_random_plain();
            end else begin
                emit_random_plain();
            end
        end
        finish_program();
        run_test("random_mix");

        $display("tests %0d, errors %0d, assertion failures %0d",
                 tests, errors, uut.u_asserts.failures);
        if (errors == 0 && uut.u_asserts.failures == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/cpu_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_asserts (
    input logic               clk,
    input logic               reset,
    input cpu_pkg::dmem_req_t dmem,
    input cpu_pkg::wb_trace_t trace,
    input logic               stall,
    input cpu_pkg::word_t     imem_addr
);

    int failures = 0;

    // store strobes only with an access
    assert property (@(posedge clk) disable iff (reset) (dmem.wen != 4'h0) |-> dmem.en)
        else begin
            $error("dmem.wen set without dmem.en");
            failures++;
        end

    assert property (@(posedge clk) (reset && $past(reset)) |-> !trace.valid)
        else begin
            $error("trace.valid high during reset");
            failures++;
        end

    // the stalled word is fetched again from the same address
    assert property (@(posedge clk) disable iff (reset) stall |-> $stable(imem_addr))
        else begin
            $error("imem_addr moved when a stall was raised");
            failures++;
        end

    assert property (@(posedge clk) disable iff (reset) stall |=> !stall)
        else begin
            $error("stall lasted more than one cycle");
            failures++;
        end

endmodule

bind cpu_core cpu_asserts u_asserts (
    .clk       (clk),
    .reset     (reset),
    .dmem      (dmem),
    .trace     (trace),
    .stall     (stall),
    .imem_addr (imem_addr)
);

`default_nettype wire

//--- src/cpu_core.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_core (
    input  logic               clk,
    input  logic               reset,
    output cpu_pkg::word_t     imem_addr,
    input  cpu_pkg::word_t     imem_rdata,
    output cpu_pkg::dmem_req_t dmem,
    input  cpu_pkg::word_t     dmem_rdata,
    output cpu_pkg::wb_trace_t trace
);

    cpu_pkg::word_t      pc_q;
    cpu_pkg::word_t      pc_next;
    logic                if_id_valid;
    cpu_pkg::word_t      if_id_pc;

    cpu_pkg::reg_addr_t  id_rs;
    cpu_pkg::reg_addr_t  id_rt;
    cpu_pkg::word_t      rf_rs;
    cpu_pkg::word_t      rf_rt;
    cpu_pkg::word_t      id_rs_data;
    cpu_pkg::word_t      id_rt_data;
    cpu_pkg::ctrl_t      id_ctrl;
    logic                id_redirect;
    cpu_pkg::word_t      id_target;
    logic                load_use;
    logic                stall;

    cpu_pkg::id_ex_t     id_ex;
    cpu_pkg::ex_mem_t    ex_mem;
    cpu_pkg::mem_wb_t    mem_wb;
    cpu_pkg::word_t      alu_b;
    cpu_pkg::word_t      alu_result;
    logic                ex_is_load;
    cpu_pkg::word_t      mem_wdata;
    cpu_pkg::stage_fwd_t ex_fwd;
    cpu_pkg::stage_fwd_t mem_fwd;
    cpu_pkg::stage_fwd_t wb_fwd;

    // fetch, pc_q is the address of the delay-slot side of ID
    assign stall     = load_use && if_id_valid;
    assign pc_next   = (if_id_valid && id_redirect) ? id_target : pc_q + 32'd4;
    assign imem_addr = stall ? if_id_pc : pc_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q        <= cpu_pkg::reset_pc;
            if_id_valid <= 1'b0;
        end else if (!stall) begin
            pc_q        <= pc_next;
            if_id_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            if_id_pc <= pc_q;
        end
    end

    // decode
    assign id_rs = imem_rdata[25:21];
    assign id_rt = imem_rdata[20:16];

    regfile u_regfile (
        .clk     (clk),
        .reset   (reset),
        .raddr_a (id_rs),
        .rdata_a (rf_rs),
        .raddr_b (id_rt),
        .rdata_b (rf_rt),
        .wen     (mem_wb.valid && mem_wb.reg_write),
        .waddr   (mem_wb.dest),
        .wdata   (mem_wb.wdata)
    );

    forward_unit u_forward (
        .rs         (id_rs),
        .rt         (id_rt),
        .rf_rs      (rf_rs),
        .rf_rt      (rf_rt),
        .ex_fwd     (ex_fwd),
        .mem_fwd    (mem_fwd),
        .wb_fwd     (wb_fwd),
        .ex_is_load (ex_is_load),
        .rs_data    (id_rs_data),
        .rt_data    (id_rt_data),
        .stall      (load_use)
    );

    decode_unit u_decode (
        .instr    (imem_rdata),
        .rs_data  (id_rs_data),
        .rt_data  (id_rt_data),
        .pc_if    (pc_q),
        .ctrl     (id_ctrl),
        .redirect (id_redirect),
        .target   (id_target)
    );

    // bubble into EX on a load-use stall
    always_ff @(posedge clk) begin
        if (reset) begin
            id_ex.valid <= 1'b0;
        end else begin
            id_ex <= '{valid: if_id_valid && !stall, pc: if_id_pc, rs_data: id_rs_data,
                       rt_data: id_rt_data, ctrl: id_ctrl};
        end
    end

    // execute
    assign alu_b = id_ex.ctrl.src_b_imm ? id_ex.ctrl.imm : id_ex.rt_data;

    alu u_alu (
        .op     (id_ex.ctrl.alu_op),
        .a      (id_ex.rs_data),
        .b      (alu_b),
        .shamt  (id_ex.ctrl.shamt),
        .result (alu_result)
    );

    assign ex_is_load = id_ex.valid && id_ex.ctrl.mem_read;
    assign ex_fwd     = '{write: id_ex.valid && id_ex.ctrl.reg_write,
                          dest: id_ex.ctrl.dest, value: alu_result};

    // whole-word access only
    assign dmem = '{en: id_ex.valid && (id_ex.ctrl.mem_read || id_ex.ctrl.mem_write),
                    wen: {4{id_ex.valid && id_ex.ctrl.mem_write}},
                    addr: alu_result, wdata: id_ex.rt_data};

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_mem.valid <= 1'b0;
        end else begin
            ex_mem <= '{valid: id_ex.valid, pc: id_ex.pc, result: alu_result,
                        store_data: id_ex.rt_data, reg_write: id_ex.ctrl.reg_write,
                        dest: id_ex.ctrl.dest, mem_read: id_ex.ctrl.mem_read};
        end
    end

    // memory, load data lands here
    assign mem_wdata = ex_mem.mem_read ? dmem_rdata : ex_mem.result;
    assign mem_fwd   = '{write: ex_mem.valid && ex_mem.reg_write,
                         dest: ex_mem.dest, value: mem_wdata};

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_wb.valid <= 1'b0;
        end else begin
            mem_wb <= '{valid: ex_mem.valid, pc: ex_mem.pc, reg_write: ex_mem.reg_write,
                        dest: ex_mem.dest, wdata: mem_wdata};
        end
    end

    // writeback
    assign wb_fwd = '{write: mem_wb.valid && mem_wb.reg_write,
                      dest: mem_wb.dest, value: mem_wb.wdata};
    assign trace  = '{valid: mem_wb.valid && mem_wb.reg_write, pc: mem_wb.pc,
                      wnum: mem_wb.dest, wdata: mem_wb.wdata};

endmodule

`default_nettype wire

//--- src/alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu (
    input  cpu_pkg::alu_op_t op,
    input  cpu_pkg::word_t   a,
    input  cpu_pkg::word_t   b,
    input  logic [4:0]       shamt,
    output cpu_pkg::word_t   result
);

    always_comb begin
        case (op)
            cpu_pkg::alu_add: result = a + b;
            cpu_pkg::alu_sub: result = a - b;
            cpu_pkg::alu_and: result = a & b;
            cpu_pkg::alu_or:  result = a | b;
            cpu_pkg::alu_xor: result = a ^ b;
            cpu_pkg::alu_nor: result = ~(a | b);
            cpu_pkg::alu_slt: begin
                result = {31'b0, $signed(a) < $signed(b)};
            end
            cpu_pkg::alu_sltu: begin
                result = {31'b0, a < b};
            end
            // shift amount from the instruction, operand from rt
            cpu_pkg::alu_sll: result = b << shamt;
            cpu_pkg::alu_lui: result = {b[15:0], 16'h0000};
            default:          result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- src/forward_unit.sv
`timescale 1ns/10ps
`default_nettype none

module forward_unit (
    input  cpu_pkg::reg_addr_t  rs,
    input  cpu_pkg::reg_addr_t  rt,
    input  cpu_pkg::word_t      rf_rs,
    input  cpu_pkg::word_t      rf_rt,
    input  cpu_pkg::stage_fwd_t ex_fwd,
    input  cpu_pkg::stage_fwd_t mem_fwd,
    input  cpu_pkg::stage_fwd_t wb_fwd,
    input  logic                ex_is_load,
    output cpu_pkg::word_t      rs_data,
    output cpu_pkg::word_t      rt_data,
    output logic                stall
);

    logic ex_hit_rs;
    logic ex_hit_rt;

    // youngest producer wins
    function automatic cpu_pkg::word_t bypass(
        input cpu_pkg::reg_addr_t  r,
        input cpu_pkg::word_t      rf_value,
        input cpu_pkg::stage_fwd_t ex,
        input cpu_pkg::stage_fwd_t mem,
        input cpu_pkg::stage_fwd_t wb
    );
        cpu_pkg::word_t value;
        value = rf_value;
        if (r != '0) begin
            if (ex.write && ex.dest == r) begin
                value = ex.value;
            end else if (mem.write && mem.dest == r) begin
                value = mem.value;
            end else if (wb.write && wb.dest == r) begin
                value = wb.value;
            end
        end
        return value;
    endfunction

    assign rs_data = bypass(rs, rf_rs, ex_fwd, mem_fwd, wb_fwd);
    assign rt_data = bypass(rt, rf_rt, ex_fwd, mem_fwd, wb_fwd);

    // load data is not ready until MEM
    assign ex_hit_rs = ex_fwd.write && ex_fwd.dest == rs && rs != '0;
    assign ex_hit_rt = ex_fwd.write && ex_fwd.dest == rt && rt != '0;
    assign stall     = ex_is_load && (ex_hit_rs || ex_hit_rt);

endmodule

`default_nettype wire

//--- src/decode_unit.sv
`timescale 1ns/10ps
`default_nettype none

module decode_unit (
    input  cpu_pkg::word_t instr,
    input  cpu_pkg::word_t rs_data,
    input  cpu_pkg::word_t rt_data,
    input  cpu_pkg::word_t pc_if,
    output cpu_pkg::ctrl_t ctrl,
    output logic           redirect,
    output cpu_pkg::word_t target
);

    logic [5:0]         opcode;
    logic [5:0]         funct;
    cpu_pkg::reg_addr_t rt;
    cpu_pkg::reg_addr_t rd;
    logic [15:0]        imm16;
    cpu_pkg::word_t     sign_imm;
    cpu_pkg::word_t     zero_imm;
    logic               writes;
    logic               branch_taken;

    assign opcode   = instr[31:26];
    assign rt       = instr[20:16];
    assign rd       = instr[15:11];
    assign funct    = instr[5:0];
    assign imm16    = instr[15:0];
    assign sign_imm = {{16{imm16[15]}}, imm16};
    assign zero_imm = {16'h0000, imm16};

    always_comb begin
        ctrl.alu_op    = cpu_pkg::alu_add;
        ctrl.src_b_imm = 1'b1;
        ctrl.imm       = sign_imm;
        ctrl.shamt     = instr[10:6];
        ctrl.dest      = rt;
        ctrl.mem_read  = 1'b0;
        ctrl.mem_write = 1'b0;
        writes         = 1'b0;
        case (opcode)
            cpu_pkg::op_special: begin
                ctrl.src_b_imm = 1'b0;
                ctrl.dest      = rd;
                writes         = 1'b1;
                case (funct)
                    cpu_pkg::fn_addu: ctrl.alu_op = cpu_pkg::alu_add;
                    cpu_pkg::fn_subu: ctrl.alu_op = cpu_pkg::alu_sub;
                    cpu_pkg::fn_and:  ctrl.alu_op = cpu_pkg::alu_and;
                    cpu_pkg::fn_or:   ctrl.alu_op = cpu_pkg::alu_or;
                    cpu_pkg::fn_xor:  ctrl.alu_op = cpu_pkg::alu_xor;
                    cpu_pkg::fn_nor:  ctrl.alu_op = cpu_pkg::alu_nor;
                    cpu_pkg::fn_slt:  ctrl.alu_op = cpu_pkg::alu_slt;
                    cpu_pkg::fn_sltu: ctrl.alu_op = cpu_pkg::alu_sltu;
                    cpu_pkg::fn_sll:  ctrl.alu_op = cpu_pkg::alu_sll;
                    default:          writes      = 1'b0;
                endcase
            end
            cpu_pkg::op_addiu: writes = 1'b1;
            cpu_pkg::op_slti: begin
                ctrl.alu_op = cpu_pkg::alu_slt;
                writes      = 1'b1;
            end
            cpu_pkg::op_andi: begin
                ctrl.alu_op = cpu_pkg::alu_and;
                ctrl.imm    = zero_imm;
                writes      = 1'b1;
            end
            cpu_pkg::op_ori: begin
                ctrl.alu_op = cpu_pkg::alu_or;
                ctrl.imm    = zero_imm;
                writes      = 1'b1;
            end
            cpu_pkg::op_lui: begin
                ctrl.alu_op = cpu_pkg::alu_lui;
                ctrl.imm    = zero_imm;
                writes      = 1'b1;
            end
            cpu_pkg::op_lw: begin
                ctrl.mem_read = 1'b1;
                writes        = 1'b1;
            end
            cpu_pkg::op_sw: ctrl.mem_write = 1'b1;
            default: writes = 1'b0;
        endcase
        // nop and r0 targets drop out here
        ctrl.reg_write = writes && (ctrl.dest != '0);
    end

    // resolved on bypassed operands
    assign branch_taken = (opcode == cpu_pkg::op_beq && rs_data == rt_data)
                       || (opcode == cpu_pkg::op_bne && rs_data != rt_data);

    assign redirect = branch_taken || (opcode == cpu_pkg::op_j);
    assign target   = (opcode == cpu_pkg::op_j)
                    ? {pc_if[31:28], instr[25:0], 2'b00}
                    : pc_if + {sign_imm[29:0], 2'b00};

endmodule

`default_nettype wire

//--- src/regfile.sv
`timescale 1ns/10ps
`default_nettype none

module regfile (
    input  logic               clk,
    input  logic               reset,
    input  cpu_pkg::reg_addr_t raddr_a,
    output cpu_pkg::word_t     rdata_a,
    input  cpu_pkg::reg_addr_t raddr_b,
    output cpu_pkg::word_t     rdata_b,
    input  logic               wen,
    input  cpu_pkg::reg_addr_t waddr,
    input  cpu_pkg::word_t     wdata
);

    cpu_pkg::word_t regs [32];

    // r0 is never written
    always_ff @(posedge clk) begin
        if (!reset && wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
    assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

endmodule

`default_nettype wire

//--- src/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    localparam word_t reset_pc = 32'h0000_0000;

    // primary opcodes
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_j       = 6'h02;
    localparam logic [5:0] op_beq     = 6'h04;
    localparam logic [5:0] op_bne     = 6'h05;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_slti    = 6'h0a;
    localparam logic [5:0] op_andi    = 6'h0c;
    localparam logic [5:0] op_ori     = 6'h0d;
    localparam logic [5:0] op_lui     = 6'h0f;
    localparam logic [5:0] op_lw      = 6'h23;
    localparam logic [5:0] op_sw      = 6'h2b;

    // funct field under op_special
    localparam logic [5:0] fn_sll  = 6'h00;
    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_subu = 6'h23;
    localparam logic [5:0] fn_and  = 6'h24;
    localparam logic [5:0] fn_or   = 6'h25;
    localparam logic [5:0] fn_xor  = 6'h26;
    localparam logic [5:0] fn_nor  = 6'h27;
    localparam logic [5:0] fn_slt  = 6'h2a;
    localparam logic [5:0] fn_sltu = 6'h2b;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_nor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_lui
    } alu_op_t;

    typedef struct packed {
        alu_op_t     alu_op;
        logic        src_b_imm;
        word_t       imm;
        logic [4:0]  shamt;
        logic        reg_write;
        reg_addr_t   dest;
        logic        mem_read;
        logic        mem_write;
    } ctrl_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t rs_data;
        word_t rt_data;
        ctrl_t ctrl;
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        word_t     result;
        word_t     store_data;
        logic      reg_write;
        reg_addr_t dest;
        logic      mem_read;
    } ex_mem_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        logic      reg_write;
        reg_addr_t dest;
        word_t     wdata;
    } mem_wb_t;

    typedef struct packed {
        logic       en;
        logic [3:0] wen;
        word_t      addr;
        word_t      wdata;
    } dmem_req_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        reg_addr_t wnum;
        word_t     wdata;
    } wb_trace_t;

    // one bypass source, write already masked by stage valid
    typedef struct packed {
        logic      write;
        reg_addr_t dest;
        word_t     value;
    } stage_fwd_t;

endpackage

`default_nettype wire
